//--- design/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// fetch starts here and no exception is taken at this pc
`define PC_RESET_ADDR   32'hbfc0_0000

// cp0 register numbers
`define CP0_STATUS      5'd12
`define CP0_CAUSE       5'd13
`define CP0_EPC         5'd14

// only the software interrupt bits of cause are writable
`define CP0_CAUSE_MASK  32'h0000_0300

`define RAM_WORDS       1024

// cause.ExcCode values
`define EXC_INT         5'h00
`define EXC_ADEL        5'h04
`define EXC_ADES        5'h05
`define EXC_SYS         5'h08
`define EXC_RI          5'h0a
`define EXC_OV          5'h0c
`define EXC_ERET        5'h0e

`endif

//--- design/excp_pkg.sv
`default_nettype none

package excp_pkg;

    // flags raised by the execute stage
    typedef struct packed {
        logic syscall;
        logic inv_inst;
        logic overflow;
        logic eret;
    } excp_flags_t;

    typedef enum logic [2:0] {
        EXCP_NONE,
        EXCP_INT,
        EXCP_SYS,
        EXCP_RI,
        EXCP_OV,
        EXCP_ADEL,
        EXCP_ADES,
        EXCP_ERET
    } excp_e;

    typedef struct packed {
        logic        we;
        logic [4:0]  addr;
        logic [31:0] data;
    } cp0_wr_t;

    typedef struct packed {
        logic [31:0] status;
        logic [31:0] cause;
        logic [31:0] epc;
    } cp0_state_t;

endpackage

`default_nettype wire

//--- design/cpu_types_pkg.sv
`default_nettype none

package cpu_types_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  byte_mask_t;

    typedef enum logic [3:0] {
        OP_NOP,
        OP_LB,
        OP_LBU,
        OP_LH,
        OP_LHU,
        OP_LW,
        OP_SB,
        OP_SH,
        OP_SW
    } mem_op_e;

    // addr is a word address
    typedef struct packed {
        logic        valid;
        logic        write;
        logic [29:0] addr;
        word_t       wdata;
        byte_mask_t  mask;
    } mem_req_t;

    typedef struct packed {
        logic               valid;
        logic               wreg_we;
        reg_addr_t          wreg_addr;
        word_t              wreg_data;
        logic               hilo_we;
        word_t              hi;
        word_t              lo;
        excp_pkg::cp0_wr_t  cp0_wr;
        excp_pkg::excp_e    excp;
    } wb_t;

endpackage

`default_nettype wire

//--- design/unified_ram.sv
`default_nettype none
`timescale 1ns/10ps
`include "cpu_defs.svh"

module unified_ram (
    input  logic                     clk,
    input  cpu_types_pkg::mem_req_t  req_i,
    output cpu_types_pkg::word_t     rdata_o
);
    import cpu_types_pkg::*;

    localparam int AW = $clog2(`RAM_WORDS);

    word_t          mem [`RAM_WORDS];
    word_t          rdata_q;
    logic [AW-1:0]  idx;

    // low word address bits select the row
    assign idx = req_i.addr[AW-1:0];

    always_ff @(posedge clk) begin
        if (req_i.valid) begin
            if (req_i.write) begin
                for (int b = 0; b < 4; b++) begin
                    if (req_i.mask[b]) begin
                        mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
                    end
                end
            end
            rdata_q <= mem[idx];
        end
    end

    assign rdata_o = rdata_q;

endmodule

`default_nettype wire

//--- design/mem_arbiter.sv
`default_nettype none
`timescale 1ns/10ps

module mem_arbiter (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  cpu_types_pkg::mem_req_t  data_req_i,
    input  cpu_types_pkg::mem_req_t  fetch_req_i,
    output logic                     fetch_grant_o,
    output cpu_types_pkg::mem_req_t  ram_req_o,
    input  cpu_types_pkg::word_t     ram_rdata_i,
    output cpu_types_pkg::word_t     data_rdata_o,
    output cpu_types_pkg::word_t     fetch_rdata_o
);
    import cpu_types_pkg::*;

    // high when the read in flight belongs to fetch
    logic owner_q;

    // data always wins
    assign fetch_grant_o = fetch_req_i.valid & ~data_req_i.valid;
    assign ram_req_o     = data_req_i.valid ? data_req_i : fetch_req_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            owner_q <= 1'b0;
        end else begin
            owner_q <= fetch_grant_o;
        end
    end

    assign data_rdata_o  = owner_q ? '0 : ram_rdata_i;
    assign fetch_rdata_o = owner_q ? ram_rdata_i : '0;

endmodule

`default_nettype wire

//--- design/fetch_port.sv
`default_nettype none
`timescale 1ns/10ps
`include "cpu_defs.svh"

module fetch_port (
    input  logic                     clk,
    input  logic                     rst_n_i,
    output cpu_types_pkg::mem_req_t  fetch_req_o,
    input  logic                     fetch_grant_i,
    input  cpu_types_pkg::word_t     fetch_rdata_i,
    output cpu_types_pkg::word_t     instr_o,
    output cpu_types_pkg::word_t     instr_pc_o,
    output logic                     instr_valid_o
);
    import cpu_types_pkg::*;

    word_t pc_q;
    word_t instr_pc_q;
    logic  instr_valid_q;

    // read the word at pc every cycle
    assign fetch_req_o = '{valid: 1'b1, write: 1'b0, addr: pc_q[31:2],
                           wdata: '0, mask: 4'b1111};

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q          <= `PC_RESET_ADDR;
            instr_valid_q <= 1'b0;
        end else begin
            instr_valid_q <= fetch_grant_i;
            if (fetch_grant_i) begin
                pc_q <= pc_q + 32'd4;
            end
        end
    end

    // pc travels with the pending read
    always_ff @(posedge clk) begin
        if (fetch_grant_i) begin
            instr_pc_q <= pc_q;
        end
    end

    assign instr_o       = fetch_rdata_i;
    assign instr_pc_o    = instr_pc_q;
    assign instr_valid_o = instr_valid_q;

endmodule

`default_nettype wire

//--- design/cp0_regs.sv
`default_nettype none
`timescale 1ns/10ps
`include "cpu_defs.svh"

module cp0_regs (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  excp_pkg::cp0_wr_t     cp0_wr_i,
    input  excp_pkg::excp_e       excp_i,
    input  logic [31:0]           excp_pc_i,
    input  logic [5:0]            int_i,
    output excp_pkg::cp0_state_t  state_o
);
    import excp_pkg::*;

    logic [31:0] status_q;
    logic [31:0] cause_q;
    logic [31:0] epc_q;

    function automatic logic [4:0] exc_code(excp_e e);
        case (e)
            EXCP_SYS:  return `EXC_SYS;
            EXCP_RI:   return `EXC_RI;
            EXCP_OV:   return `EXC_OV;
            EXCP_ADEL: return `EXC_ADEL;
            EXCP_ADES: return `EXC_ADES;
            EXCP_ERET: return `EXC_ERET;
            default:   return `EXC_INT;
        endcase
    endfunction

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            status_q <= '0;
            cause_q  <= '0;
            epc_q    <= '0;
        end else begin
            if (cp0_wr_i.we) begin
                case (cp0_wr_i.addr)
                    `CP0_STATUS: status_q <= cp0_wr_i.data;
                    `CP0_CAUSE:  cause_q  <= (cause_q & ~`CP0_CAUSE_MASK) |
                                             (cp0_wr_i.data & `CP0_CAUSE_MASK);
                    `CP0_EPC:    epc_q    <= cp0_wr_i.data;
                    default: ;
                endcase
            end
            // hardware lines land in IP7..IP2
            cause_q[15:10] <= int_i;
            if (excp_i == EXCP_ERET) begin
                status_q[1] <= 1'b0;
            end else if (excp_i != EXCP_NONE) begin
                status_q[1]  <= 1'b1;
                epc_q        <= excp_pc_i;
                cause_q[6:2] <= exc_code(excp_i);
            end
        end
    end

    assign state_o = '{status: status_q, cause: cause_q, epc: epc_q};

endmodule

`default_nettype wire

//--- design/mem_stage.sv
`default_nettype none
`timescale 1ns/10ps
`include "cpu_defs.svh"

module mem_stage (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      op_valid_i,
    input  cpu_types_pkg::mem_op_e    op_i,
    input  cpu_types_pkg::word_t      addr_i,
    input  cpu_types_pkg::word_t      store_data_i,
    input  logic                      wreg_we_i,
    input  cpu_types_pkg::reg_addr_t  wreg_addr_i,
    input  cpu_types_pkg::word_t      wreg_data_i,
    input  logic                      hilo_we_i,
    input  cpu_types_pkg::word_t      hi_i,
    input  cpu_types_pkg::word_t      lo_i,
    input  excp_pkg::cp0_wr_t         cp0_wr_i,
    input  cpu_types_pkg::word_t      pc_i,
    input  excp_pkg::excp_flags_t     excp_flags_i,
    input  excp_pkg::cp0_state_t      cp0_state_i,
    output cpu_types_pkg::mem_req_t   data_req_o,
    input  cpu_types_pkg::word_t      data_rdata_i,
    output cpu_types_pkg::wb_t        wb_o,
    output excp_pkg::excp_e           excp_o,
    output cpu_types_pkg::word_t      excp_pc_o
);
    import cpu_types_pkg::*;
    import excp_pkg::*;

    word_t       status_eff;
    word_t       cause_eff;
    logic        int_pend;
    logic        addr_err;
    logic        is_load;
    logic        is_store;
    logic        no_excp;
    excp_e       excp;
    wb_t         wb_q;
    mem_op_e     ld_op_q;
    logic [1:0]  ld_off_q;
    word_t       pc_q;
    logic [7:0]  rd_byte;
    logic [15:0] rd_half;

    // cp0 as it will be once the pending wb write lands
    always_comb begin
        status_eff = cp0_state_i.status;
        cause_eff  = cp0_state_i.cause;
        if (wb_q.cp0_wr.we) begin
            case (wb_q.cp0_wr.addr)
                `CP0_STATUS: status_eff = wb_q.cp0_wr.data;
                `CP0_CAUSE:  cause_eff  = (cause_eff & ~`CP0_CAUSE_MASK) |
                                          (wb_q.cp0_wr.data & `CP0_CAUSE_MASK);
                default: ;
            endcase
        end
    end

    // IP & IM, EXL clear, IE set
    assign int_pend = (|(cause_eff[15:8] & status_eff[15:8])) & ~status_eff[1] & status_eff[0];

    assign is_load  = op_i inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
    assign is_store = op_i inside {OP_SB, OP_SH, OP_SW};

    always_comb begin
        case (op_i)
            OP_LH, OP_LHU, OP_SH: addr_err = addr_i[0];
            OP_LW, OP_SW:         addr_err = |addr_i[1:0];
            default:              addr_err = 1'b0;
        endcase
    end

    always_comb begin
        excp = EXCP_NONE;
        if (op_valid_i && pc_i != `PC_RESET_ADDR) begin
            if (int_pend) begin
                excp = EXCP_INT;
            end else if (excp_flags_i.syscall) begin
                excp = EXCP_SYS;
            end else if (excp_flags_i.inv_inst) begin
                excp = EXCP_RI;
            end else if (excp_flags_i.overflow) begin
                excp = EXCP_OV;
            end else if (addr_err) begin
                excp = is_store ? EXCP_ADES : EXCP_ADEL;
            end else if (excp_flags_i.eret) begin
                excp = EXCP_ERET;
            end
        end
    end

    assign no_excp = (excp == EXCP_NONE);

    // byte lanes for stores
    always_comb begin
        data_req_o       = '0;
        data_req_o.valid = op_valid_i & (is_load | is_store) & no_excp;
        data_req_o.write = is_store;
        data_req_o.addr  = addr_i[31:2];
        data_req_o.mask  = 4'b1111;
        case (op_i)
            OP_SB: begin
                data_req_o.wdata = {4{store_data_i[7:0]}};
                data_req_o.mask  = 4'b0001 << addr_i[1:0];
            end
            OP_SH: begin
                data_req_o.wdata = {2{store_data_i[15:0]}};
                data_req_o.mask  = addr_i[1] ? 4'b1100 : 4'b0011;
            end
            OP_SW: data_req_o.wdata = store_data_i;
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_q    <= '0;
            ld_op_q <= OP_NOP;
        end else begin
            wb_q.valid        <= op_valid_i;
            wb_q.wreg_we      <= op_valid_i & wreg_we_i & no_excp;
            wb_q.wreg_addr    <= wreg_addr_i;
            wb_q.wreg_data    <= wreg_data_i;
            wb_q.hilo_we      <= op_valid_i & hilo_we_i & no_excp;
            wb_q.hi           <= hi_i;
            wb_q.lo           <= lo_i;
            wb_q.cp0_wr.we    <= op_valid_i & cp0_wr_i.we;
            wb_q.cp0_wr.addr  <= cp0_wr_i.addr;
            wb_q.cp0_wr.data  <= cp0_wr_i.data;
            wb_q.excp         <= excp;
            ld_op_q           <= (op_valid_i && is_load && no_excp) ? op_i : OP_NOP;
        end
    end

    always_ff @(posedge clk) begin
        ld_off_q <= addr_i[1:0];
        pc_q     <= pc_i;
    end

    // load data returns in the wb cycle
    assign rd_byte = data_rdata_i[8*ld_off_q +: 8];
    assign rd_half = ld_off_q[1] ? data_rdata_i[31:16] : data_rdata_i[15:0];

    always_comb begin
        wb_o = wb_q;
        case (ld_op_q)
            OP_LB:  wb_o.wreg_data = {{24{rd_byte[7]}}, rd_byte};
            OP_LBU: wb_o.wreg_data = {24'b0, rd_byte};
            OP_LH:  wb_o.wreg_data = {{16{rd_half[15]}}, rd_half};
            OP_LHU: wb_o.wreg_data = {16'b0, rd_half};
            OP_LW:  wb_o.wreg_data = data_rdata_i;
            default: ;
        endcase
    end

    assign excp_o    = wb_q.excp;
    assign excp_pc_o = pc_q;

endmodule

`default_nettype wire

//--- design/mem_subsys_top.sv
`default_nettype none
`timescale 1ns/10ps

module mem_subsys_top (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      op_valid_i,
    input  cpu_types_pkg::mem_op_e    op_i,
    input  cpu_types_pkg::word_t      addr_i,
    input  cpu_types_pkg::word_t      store_data_i,
    input  logic                      wreg_we_i,
    input  cpu_types_pkg::reg_addr_t  wreg_addr_i,
    input  cpu_types_pkg::word_t      wreg_data_i,
    input  logic                      hilo_we_i,
    input  cpu_types_pkg::word_t      hi_i,
    input  cpu_types_pkg::word_t      lo_i,
    input  excp_pkg::cp0_wr_t         cp0_wr_i,
    input  cpu_types_pkg::word_t      pc_i,
    input  excp_pkg::excp_flags_t     excp_flags_i,
    input  logic [5:0]                int_i,
    output cpu_types_pkg::wb_t        wb_o,
    output cpu_types_pkg::word_t      instr_o,
    output cpu_types_pkg::word_t      instr_pc_o,
    output logic                      instr_valid_o
);
    import cpu_types_pkg::*;
    import excp_pkg::*;

    mem_req_t    data_req;
    mem_req_t    fetch_req;
    mem_req_t    ram_req;
    logic        fetch_grant;
    word_t       ram_rdata;
    word_t       data_rdata;
    word_t       fetch_rdata;
    cp0_state_t  cp0_state;
    excp_e       excp;
    word_t       excp_pc;

    mem_stage mem_stage_i (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .op_valid_i   (op_valid_i),
        .op_i         (op_i),
        .addr_i       (addr_i),
        .store_data_i (store_data_i),
        .wreg_we_i    (wreg_we_i),
        .wreg_addr_i  (wreg_addr_i),
        .wreg_data_i  (wreg_data_i),
        .hilo_we_i    (hilo_we_i),
        .hi_i         (hi_i),
        .lo_i         (lo_i),
        .cp0_wr_i     (cp0_wr_i),
        .pc_i         (pc_i),
        .excp_flags_i (excp_flags_i),
        .cp0_state_i  (cp0_state),
        .data_req_o   (data_req),
        .data_rdata_i (data_rdata),
        .wb_o         (wb_o),
        .excp_o       (excp),
        .excp_pc_o    (excp_pc)
    );

    cp0_regs cp0_regs_i (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .cp0_wr_i  (wb_o.cp0_wr),
        .excp_i    (excp),
        .excp_pc_i (excp_pc),
        .int_i     (int_i),
        .state_o   (cp0_state)
    );

    mem_arbiter mem_arbiter_i (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .data_req_i    (data_req),
        .fetch_req_i   (fetch_req),
        .fetch_grant_o (fetch_grant),
        .ram_req_o     (ram_req),
        .ram_rdata_i   (ram_rdata),
        .data_rdata_o  (data_rdata),
        .fetch_rdata_o (fetch_rdata)
    );

    fetch_port fetch_port_i (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .fetch_req_o   (fetch_req),
        .fetch_grant_i (fetch_grant),
        .fetch_rdata_i (fetch_rdata),
        .instr_o       (instr_o),
        .instr_pc_o    (instr_pc_o),
        .instr_valid_o (instr_valid_o)
    );

    unified_ram unified_ram_i (
        .clk     (clk),
        .req_i   (ram_req),
        .rdata_o (ram_rdata)
    );

endmodule

`default_nettype wire

//--- test/mem_subsys_properties.sv
`default_nettype none
`timescale 1ns/10ps

module mem_subsys_properties (
    input  logic  clk,
    input  logic  rst_n_i,
    input  logic  data_valid_i,
    input  logic  data_write_i,
    input  logic  fetch_grant_i,
    input  logic  owner_i
);

    // data side always wins the port
    no_grant_under_data: assert property (
        @(posedge clk) disable iff (!rst_n_i) data_valid_i |-> !fetch_grant_i
    ) else $error("fetch granted while data request is valid");

    one_read_in_flight: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        $onehot0({data_valid_i & ~data_write_i, fetch_grant_i})
    ) else $error("two reads issued in one cycle");

    // response goes to the client that issued the read
    fetch_read_returns: assert property (
        @(posedge clk) disable iff (!rst_n_i) fetch_grant_i |=> owner_i
    ) else $error("granted fetch read not routed back to fetch");

    data_read_returns: assert property (
        @(posedge clk) disable iff (!rst_n_i) (data_valid_i && !data_write_i) |=> !owner_i
    ) else $error("data read not routed back to data side");

endmodule

bind mem_arbiter mem_subsys_properties props_i (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .data_valid_i  (data_req_i.valid),
    .data_write_i  (data_req_i.write),
    .fetch_grant_i (fetch_grant_o),
    .owner_i       (owner_q)
);

`default_nettype wire

//--- test/mem_subsys_tb.sv
`default_nettype none
`timescale 1ns/10ps
`include "cpu_defs.svh"

module mem_subsys_tb;
    import cpu_types_pkg::*;
    import excp_pkg::*;

    localparam int TEST_CYCLES = 64 + 105 + 7 + 13 + 9 + 42;
    localparam int MAX_CYCLES  = 8 + TEST_CYCLES + 50;

    logic         clk;
    logic         rst_n_i;
    logic         op_valid_i;
    mem_op_e      op_i;
    word_t        addr_i;
    word_t        store_data_i;
    logic         wreg_we_i;
    reg_addr_t    wreg_addr_i;
    word_t        wreg_data_i;
    logic         hilo_we_i;
    word_t        hi_i;
    word_t        lo_i;
    cp0_wr_t      cp0_wr_i;
    word_t        pc_i;
    excp_flags_t  excp_flags_i;
    logic [5:0]   int_i;
    wb_t          wb_o;
    word_t        instr_o;
    word_t        instr_pc_o;
    logic         instr_valid_o;

    // byte model of the low 4 KiB the RAM index sees
    logic [7:0]   mem_m [4096];
    bit           known_m [4096];

    logic [31:0]  rng;
    word_t        op_pc;
    word_t        fetch_pc_exp;
    int           errors;
    int           err_mark;
    int           tests_run;
    int           tests_failed;
    int           cycles;
    int           instr_checked;
    int           fetch_gaps;
    bit           fetch_seen;

    bit           exp_valid;
    excp_e        exp_excp;
    logic         exp_wreg_we;
    logic         exp_hilo_we;
    word_t        exp_data;
    reg_addr_t    exp_addr;
    word_t        exp_hi;
    word_t        exp_lo;
    cp0_wr_t      exp_cp0;

    mem_op_e      st_op [7] = '{OP_SB, OP_SB, OP_SB, OP_SB, OP_SH, OP_SH, OP_SW};
    int           st_off [7] = '{0, 1, 2, 3, 0, 2, 0};

    mem_subsys_top dut_i (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic word_t take_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic word_t take_pc();
        op_pc = op_pc + 32'd4;
        return op_pc;
    endfunction

    function automatic word_t model_word(input logic [11:0] b);
        return {mem_m[{b[11:2], 2'd3}], mem_m[{b[11:2], 2'd2}],
                mem_m[{b[11:2], 2'd1}], mem_m[{b[11:2], 2'd0}]};
    endfunction

    function automatic word_t load_value(input mem_op_e op, input logic [11:0] b);
        logic [7:0]  by;
        logic [15:0] h;
        by = mem_m[b];
        h  = {mem_m[{b[11:1], 1'b1}], mem_m[{b[11:1], 1'b0}]};
        case (op)
            OP_LB:   return {{24{by[7]}}, by};
            OP_LBU:  return {24'h0, by};
            OP_LH:   return {{16{h[15]}}, h};
            OP_LHU:  return {16'h0, h};
            default: return model_word(b);
        endcase
    endfunction

    task automatic model_store(input mem_op_e op, input logic [11:0] b, input word_t d);
        int n;
        logic [11:0] base;
        n = (op == OP_SB) ? 1 : (op == OP_SH) ? 2 : 4;
        base = (op == OP_SB) ? b : (op == OP_SH) ? {b[11:1], 1'b0} : {b[11:2], 2'd0};
        for (int i = 0; i < n; i++) begin
            mem_m[base + 12'(i)]   = d[8*i +: 8];
            known_m[base + 12'(i)] = 1'b1;
        end
    endtask

    task automatic fail_check(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic check_wb();
        assert (wb_o.valid == exp_valid) else fail_check("wb valid wrong");
        if (exp_valid) begin
            assert (wb_o.excp == exp_excp)
                else fail_check($sformatf("excp %0d, expected %0d", wb_o.excp, exp_excp));
            assert (wb_o.wreg_we == exp_wreg_we) else fail_check("reg write enable wrong");
            assert (wb_o.hilo_we == exp_hilo_we) else fail_check("hilo write enable wrong");
            assert (wb_o.wreg_data == exp_data)
                else fail_check($sformatf("wb data %h, expected %h", wb_o.wreg_data, exp_data));
            assert (wb_o.wreg_addr == exp_addr)
                else fail_check($sformatf("wb reg %0d, expected %0d", wb_o.wreg_addr, exp_addr));
            assert (wb_o.hi == exp_hi && wb_o.lo == exp_lo)
                else fail_check($sformatf("hi/lo %h/%h, expected %h/%h",
                                          wb_o.hi, wb_o.lo, exp_hi, exp_lo));
            assert (wb_o.cp0_wr == exp_cp0)
                else fail_check($sformatf("cp0 write %h, expected %h", wb_o.cp0_wr, exp_cp0));
        end
    endtask

    // advance one clock and check the op that just reached wb
    task automatic tick();
        @(posedge clk);
        #1;
        check_wb();
        #1;
    endtask

    task automatic idle(input int n);
        for (int i = 0; i < n; i++) begin
            op_valid_i   = 1'b0;
            op_i         = OP_NOP;
            cp0_wr_i     = '0;
            excp_flags_i = '0;
            exp_valid    = 1'b0;
            tick();
        end
    endtask

    task automatic issue(input mem_op_e op, input word_t a, input word_t pc,
                         input excp_flags_t fl, input cp0_wr_t cw, input excp_e x);
        bit none;
        none         = (x == EXCP_NONE);
        op_valid_i   = 1'b1;
        op_i         = op;
        addr_i       = a;
        store_data_i = take_rand();
        wreg_we_i    = 1'b1;
        wreg_addr_i  = 5'(take_rand());
        wreg_data_i  = take_rand();
        hilo_we_i    = 1'b1;
        hi_i         = take_rand();
        lo_i         = take_rand();
        cp0_wr_i     = cw;
        pc_i         = pc;
        excp_flags_i = fl;
        exp_valid    = 1'b1;
        exp_excp     = x;
        exp_wreg_we  = none;
        exp_hilo_we  = none;
        exp_data     = wreg_data_i;
        exp_addr     = wreg_addr_i;
        exp_hi       = hi_i;
        exp_lo       = lo_i;
        exp_cp0      = cw;
        if (none && op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW}) begin
            exp_data = load_value(op, a[11:0]);
        end
        if (none && op inside {OP_SB, OP_SH, OP_SW}) begin
            model_store(op, a[11:0], store_data_i);
        end
        tick();
    endtask

    task automatic report(input string name);
        int e;
        e = errors - err_mark;
        tests_run++;
        if (e != 0) begin
            tests_failed++;
        end
        $display("test %s: %s (%0d errors)", name, (e == 0) ? "ok" : "FAILED", e);
        err_mark = errors;
    endtask

    // wb follows every op by exactly one cycle
    wb_follows_op: assert property (
        @(posedge clk) disable iff (!rst_n_i) op_valid_i |=> wb_o.valid
    ) else fail_check("no wb one cycle after op");

    wb_only_after_op: assert property (
        @(posedge clk) disable iff (!rst_n_i) !op_valid_i |=> !wb_o.valid
    ) else fail_check("wb valid without an op");

    // fetch stream monitor
    always begin
        @(posedge clk);
        #1;
        if (rst_n_i) begin
            if (instr_valid_o) begin
                assert (instr_pc_o == fetch_pc_exp)
                    else fail_check($sformatf("fetch pc %h, expected %h",
                                              instr_pc_o, fetch_pc_exp));
                if (known_m[{instr_pc_o[11:2], 2'd0}] && known_m[{instr_pc_o[11:2], 2'd1}] &&
                    known_m[{instr_pc_o[11:2], 2'd2}] && known_m[{instr_pc_o[11:2], 2'd3}]) begin
                    assert (instr_o == model_word(instr_pc_o[11:0]))
                        else fail_check($sformatf("instr %h at pc %h", instr_o, instr_pc_o));
                    instr_checked++;
                end
                fetch_pc_exp = fetch_pc_exp + 32'd4;
                fetch_seen   = 1'b1;
            end else if (fetch_seen) begin
                fetch_gaps++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: run went past %0d cycles without finishing", MAX_CYCLES);
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        word_t w;
        word_t pc_b;
        clk          = 1'b0;
        rst_n_i      = 1'b0;
        op_valid_i   = 1'b0;
        op_i         = OP_NOP;
        addr_i       = '0;
        store_data_i = '0;
        wreg_we_i    = 1'b0;
        wreg_addr_i  = '0;
        wreg_data_i  = '0;
        hilo_we_i    = 1'b0;
        hi_i         = '0;
        lo_i         = '0;
        cp0_wr_i     = '0;
        pc_i         = '0;
        excp_flags_i = '0;
        int_i        = '0;
        rng          = 32'd78;
        op_pc        = 32'h8000_0100;
        fetch_pc_exp = `PC_RESET_ADDR;
        exp_valid    = 1'b0;
        for (int i = 0; i < 4096; i++) begin
            known_m[i] = 1'b0;
            mem_m[i]   = '0;
        end
        repeat (8) @(posedge clk);
        #2;
        rst_n_i = 1'b1;

        // instruction words for the fetch side
        for (int i = 0; i < 64; i++) begin
            issue(OP_SW, 32'(4 * i), take_pc(), '0, '0, EXCP_NONE);
        end
        report("preload");

        for (int k = 0; k < 7; k++) begin
            w = 32'h800 + 32'(4 * k);
            issue(OP_SW, w, take_pc(), '0, '0, EXCP_NONE);
            issue(st_op[k], w + 32'(st_off[k]), take_pc(), '0, '0, EXCP_NONE);
            for (int off = 0; off < 4; off++) begin
                issue(OP_LB, w + 32'(off), take_pc(), '0, '0, EXCP_NONE);
                issue(OP_LBU, w + 32'(off), take_pc(), '0, '0, EXCP_NONE);
            end
            for (int off = 0; off < 4; off += 2) begin
                issue(OP_LH, w + 32'(off), take_pc(), '0, '0, EXCP_NONE);
                issue(OP_LHU, w + 32'(off), take_pc(), '0, '0, EXCP_NONE);
            end
            issue(OP_LW, w, take_pc(), '0, '0, EXCP_NONE);
        end
        report("store and load widths");

        w = 32'h880;
        issue(OP_SW, w, take_pc(), '0, '0, EXCP_NONE);
        issue(OP_LH, w + 1, take_pc(), '0, '0, EXCP_ADEL);
        issue(OP_LHU, w + 3, take_pc(), '0, '0, EXCP_ADEL);
        issue(OP_LW, w + 2, take_pc(), '0, '0, EXCP_ADEL);
        issue(OP_SH, w + 1, take_pc(), '0, '0, EXCP_ADES);
        issue(OP_SW, w + 2, take_pc(), '0, '0, EXCP_ADES);
        issue(OP_LW, w, take_pc(), '0, '0, EXCP_NONE);
        assert (dut_i.cp0_state.cause[6:2] == `EXC_ADES)
            else fail_check("cause code is not ADES after a store address error");
        report("address errors");

        int_i = 6'b000001;
        idle(2);
        issue(OP_NOP, '0, take_pc(), '0, '{1'b1, `CP0_STATUS, 32'h0000_0401}, EXCP_NONE);
        issue(OP_LW, w + 2, `PC_RESET_ADDR, 4'b1111, '0, EXCP_NONE);
        issue(OP_LW, w + 2, take_pc(), 4'b1111, '0, EXCP_INT);
        idle(1);
        issue(OP_LW, w + 2, take_pc(), 4'b1111, '0, EXCP_SYS);
        issue(OP_LW, w + 2, take_pc(), 4'b0111, '0, EXCP_RI);
        issue(OP_LW, w + 2, take_pc(), 4'b0011, '0, EXCP_OV);
        issue(OP_LW, w + 2, take_pc(), 4'b0001, '0, EXCP_ADEL);
        issue(OP_LW, w, take_pc(), 4'b0001, '0, EXCP_ERET);
        assert (dut_i.cp0_state.cause[6:2] == `EXC_ADEL)
            else fail_check("cause code is not ADEL after a load address error");
        int_i = '0;
        idle(2);
        report("exception priority");

        issue(OP_NOP, '0, take_pc(), '0, '{1'b1, `CP0_STATUS, 32'h0}, EXCP_NONE);
        int_i = 6'b000001;
        issue(OP_NOP, '0, take_pc(), '0, '{1'b1, `CP0_STATUS, 32'h0000_0401}, EXCP_NONE);
        pc_b = take_pc();
        issue(OP_LW, w, pc_b, '0, '0, EXCP_INT);
        idle(1);
        assert (dut_i.cp0_state.epc == pc_b) else fail_check("epc does not hold the op pc");
        assert (dut_i.cp0_state.status[1]) else fail_check("EXL not set after interrupt");
        issue(OP_NOP, '0, take_pc(), 4'b0001, '0, EXCP_ERET);
        idle(1);
        issue(OP_LW, w, take_pc(), '0, '0, EXCP_INT);
        idle(1);
        int_i = '0;
        idle(1);
        report("cp0 bypass and eret");

        idle(24);
        for (int i = 0; i < 6; i++) begin
            issue(OP_LW, 32'h800 + 32'(4 * i), take_pc(), '0, '0, EXCP_NONE);
        end
        idle(12);
        assert (instr_checked > 0) else fail_check("no fetched instruction was compared");
        assert (fetch_gaps > 0) else fail_check("no fetch gap seen during data bursts");
        report("fetch stream");

        $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed,
                 errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+design
design/excp_pkg.sv
design/cpu_types_pkg.sv
design/unified_ram.sv
design/mem_arbiter.sv
design/fetch_port.sv
design/cp0_regs.sv
design/mem_stage.sv
design/mem_subsys_top.sv
test/mem_subsys_properties.sv
test/mem_subsys_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= mem_subsys_tb
FILELIST  ?= verilog.f
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "sim passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
